//--- rtl/scoreboard_defs.svh
`ifndef SCOREBOARD_DEFS_SVH
`define SCOREBOARD_DEFS_SVH

// Bus and counter widths
`define SEG_W       7
`define SCAN_W      8
`define LCD_DATA_W  8
`define INTERVAL_W  9

// Last interval value of each LCD step
`define POWER_WAIT_LEN  70
`define FUNC_SET_LEN    30
`define ENTRY_MODE_LEN  30
`define DISP_ON_LEN     30
`define LINE_LEN        20
`define HOME_LEN        400
`define CLEAR_LEN       200

// HD44780 command bytes
`define CMD_FUNC_SET    8'h3C  // 8-bit bus, two lines, 5x11 font
`define CMD_ENTRY_MODE  8'h06
`define CMD_DISP_ON     8'h0C  // Display on, cursor off
`define CMD_LINE1_ADDR  8'h80
`define CMD_LINE2_ADDR  8'hC0
`define CMD_HOME        8'h02
`define CMD_CLEAR       8'h01

`define CHAR_SPACE  8'h20
`define CHAR_HEART  8'h9D  // Heart glyph in the controller ROM

// Characters per line that carry message text
`define MSG_LEN  9

`endif

//--- rtl/scoreboard_pkg.sv
`default_nettype none

`include "scoreboard_defs.svh"

package scoreboard_pkg;

    typedef logic [1:0] led_code_t;  // 0 off, 1 red, 2 green, 3 blue
    typedef logic [2:0] rgb_t;       // Red in bit 2
    typedef logic [2:0] digit_t;

    typedef logic [`SEG_W-1:0]      seg_t;       // Segment a in the top bit
    typedef logic [`SCAN_W-1:0]     scan_pos_t;  // Active-low digit enables
    typedef logic [`LCD_DATA_W-1:0] lcd_byte_t;
    typedef logic [`INTERVAL_W-1:0] interval_t;

    typedef enum logic [2:0] {
        POWER_WAIT,
        FUNC_SET,
        ENTRY_MODE,
        DISP_ON,
        LINE1,
        LINE2,
        RETURN_HOME,
        CLEAR_DISP
    } lcd_state_e;

    // Code 3 is unused and shows as blank
    typedef enum logic [1:0] {
        SCREEN_BLANK  = 2'd0,
        SCREEN_P1_WIN = 2'd1,
        SCREEN_P2_WIN = 2'd2
    } screen_e;

    typedef struct packed {
        logic      rs;  // 1 selects data register
        logic      rw;  // 1 reads from the controller
        lcd_byte_t data;
    } lcd_bus_t;

endpackage

`default_nettype wire

//--- rtl/rgb_indicator.sv
`timescale 1ns/10ps
`default_nettype none

module rgb_indicator (
    input  wire                       clk,
    input  wire                       rst,
    input  wire scoreboard_pkg::led_code_t led_code1,
    input  wire scoreboard_pkg::led_code_t led_code2,
    output scoreboard_pkg::rgb_t      rgb1,
    output scoreboard_pkg::rgb_t      rgb2
);

    function automatic scoreboard_pkg::rgb_t decode_color(
        input scoreboard_pkg::led_code_t code
    );
        case (code)
            2'd1:    decode_color = 3'b100;  // Red
            2'd2:    decode_color = 3'b010;  // Green
            2'd3:    decode_color = 3'b001;  // Blue
            default: decode_color = 3'b000;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            rgb1 <= '0;
            rgb2 <= '0;
        end else begin
            rgb1 <= decode_color(led_code1);
            rgb2 <= decode_color(led_code2);
        end
    end

endmodule

`default_nettype wire

//--- rtl/digit_scanner.sv
`timescale 1ns/10ps
`default_nettype none

`include "scoreboard_defs.svh"

module digit_scanner (
    input  wire                          clk,
    input  wire                          rst,
    input  wire scoreboard_pkg::digit_t  digit1,
    input  wire scoreboard_pkg::digit_t  digit2,
    output scoreboard_pkg::seg_t         seg_data,
    output scoreboard_pkg::scan_pos_t    seg_pos
);

    localparam int IDX_W = $clog2(`SCAN_W);

    logic [IDX_W-1:0]     scan_idx;
    scoreboard_pkg::seg_t seg1;
    scoreboard_pkg::seg_t seg2;
    scoreboard_pkg::seg_t seg_next;

    // Segment order is a..g from the top bit
    function automatic scoreboard_pkg::seg_t decode_digit(
        input scoreboard_pkg::digit_t value
    );
        case (value)
            3'd1:    decode_digit = 7'b0110000;
            3'd2:    decode_digit = 7'b1101101;
            3'd3:    decode_digit = 7'b1111001;
            3'd4:    decode_digit = 7'b0110011;
            3'd5:    decode_digit = 7'b1011011;
            default: decode_digit = 7'b0000000;  // Blank
        endcase
    endfunction

    assign seg1 = decode_digit(digit1);
    assign seg2 = decode_digit(digit2);

    // Only the two outer positions carry a digit
    always_comb begin
        if (scan_idx == '0) begin
            seg_next = seg1;
        end else if (scan_idx == IDX_W'(`SCAN_W - 1)) begin
            seg_next = seg2;
        end else begin
            seg_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            scan_idx <= '0;
            seg_pos  <= '0;
            seg_data <= '0;
        end else begin
            scan_idx <= scan_idx + 1'b1;  // Wraps after the last position
            seg_pos  <= ~(scoreboard_pkg::scan_pos_t'(1) << scan_idx);
            seg_data <= seg_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lcd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "scoreboard_defs.svh"

module lcd_sequencer (
    input  wire                         clk,
    input  wire                         rst,
    output scoreboard_pkg::lcd_state_e  state,
    output scoreboard_pkg::interval_t   interval
);

    scoreboard_pkg::lcd_state_e next_state;
    scoreboard_pkg::interval_t  step_len;
    logic                       step_done;

    // Last interval value for the current step
    always_comb begin
        case (state)
            scoreboard_pkg::POWER_WAIT: begin
                step_len = scoreboard_pkg::interval_t'(`POWER_WAIT_LEN);
            end
            scoreboard_pkg::FUNC_SET: begin
                step_len = scoreboard_pkg::interval_t'(`FUNC_SET_LEN);
            end
            scoreboard_pkg::ENTRY_MODE: begin
                step_len = scoreboard_pkg::interval_t'(`ENTRY_MODE_LEN);
            end
            scoreboard_pkg::DISP_ON: begin
                step_len = scoreboard_pkg::interval_t'(`DISP_ON_LEN);
            end
            scoreboard_pkg::LINE1,
            scoreboard_pkg::LINE2: begin
                step_len = scoreboard_pkg::interval_t'(`LINE_LEN);
            end
            scoreboard_pkg::RETURN_HOME: begin
                step_len = scoreboard_pkg::interval_t'(`HOME_LEN);  // Slow command
            end
            default: begin
                step_len = scoreboard_pkg::interval_t'(`CLEAR_LEN);
            end
        endcase
    end

    assign step_done = (interval == step_len);

    always_comb begin
        case (state)
            scoreboard_pkg::POWER_WAIT: begin
                next_state = scoreboard_pkg::FUNC_SET;
            end
            scoreboard_pkg::FUNC_SET: begin
                next_state = scoreboard_pkg::ENTRY_MODE;
            end
            scoreboard_pkg::ENTRY_MODE: begin
                next_state = scoreboard_pkg::DISP_ON;
            end
            scoreboard_pkg::DISP_ON: begin
                next_state = scoreboard_pkg::LINE1;
            end
            scoreboard_pkg::LINE1: begin
                next_state = scoreboard_pkg::LINE2;
            end
            scoreboard_pkg::LINE2: begin
                next_state = scoreboard_pkg::RETURN_HOME;
            end
            scoreboard_pkg::RETURN_HOME: begin
                next_state = scoreboard_pkg::CLEAR_DISP;
            end
            default: begin
                next_state = scoreboard_pkg::LINE1;  // Frame repeats
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= scoreboard_pkg::POWER_WAIT;
            interval <= '0;
        end else if (step_done) begin
            state    <= next_state;
            interval <= '0;
        end else begin
            interval <= interval + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lcd_message_rom.sv
`timescale 1ns/10ps
`default_nettype none

`include "scoreboard_defs.svh"

module lcd_message_rom (
    input  wire                              clk,
    input  wire                              rst,
    input  wire scoreboard_pkg::lcd_state_e  state,
    input  wire scoreboard_pkg::interval_t   interval,
    input  wire scoreboard_pkg::screen_e     lcd_screen,
    output scoreboard_pkg::lcd_bus_t         lcd
);

    scoreboard_pkg::lcd_bus_t bus_d;

    // Character at a line position; the blank screen is all spaces
    function automatic scoreboard_pkg::lcd_byte_t text_char(
        input scoreboard_pkg::screen_e   scr,
        input logic                      second_line,
        input scoreboard_pkg::interval_t pos
    );
        text_char = `CHAR_SPACE;
        if (scr == scoreboard_pkg::SCREEN_P1_WIN || scr == scoreboard_pkg::SCREEN_P2_WIN) begin
            if (second_line) begin
                case (pos)
                    2, 3, 4, 6, 7, 8: text_char = `CHAR_HEART;
                    default:          text_char = `CHAR_SPACE;
                endcase
            end else begin
                case (pos)
                    2:       text_char = 8'h50;  // P
                    3:       text_char = (scr == scoreboard_pkg::SCREEN_P2_WIN) ? 8'h32 : 8'h31;
                    5:       text_char = 8'h57;  // W
                    6:       text_char = 8'h69;  // i
                    7:       text_char = 8'h6E;  // n
                    default: text_char = `CHAR_SPACE;
                endcase
            end
        end
    endfunction

    always_comb begin
        bus_d = '{rs: 1'b0, rw: 1'b0, data: '0};
        case (state)
            scoreboard_pkg::POWER_WAIT:  bus_d = '{rs: 1'b1, rw: 1'b1, data: '0};
            scoreboard_pkg::FUNC_SET:    bus_d.data = `CMD_FUNC_SET;
            scoreboard_pkg::ENTRY_MODE:  bus_d.data = `CMD_ENTRY_MODE;
            scoreboard_pkg::DISP_ON:     bus_d.data = `CMD_DISP_ON;
            scoreboard_pkg::RETURN_HOME: bus_d.data = `CMD_HOME;
            scoreboard_pkg::CLEAR_DISP:  bus_d.data = `CMD_CLEAR;
            default: begin
                if (interval == '0) begin  // Address set before the text
                    bus_d.data = (state == scoreboard_pkg::LINE2) ? `CMD_LINE2_ADDR
                                                                  : `CMD_LINE1_ADDR;
                end else begin
                    bus_d.rs = 1'b1;
                    if (interval > `MSG_LEN) begin
                        bus_d.data = `CHAR_SPACE;  // Pad to end of line
                    end else begin
                        bus_d.data = text_char(lcd_screen, state == scoreboard_pkg::LINE2,
                                               interval);
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd <= '{rs: 1'b1, rw: 1'b1, data: '0};
        end else begin
            lcd <= bus_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/scoreboard_top.sv
`timescale 1ns/10ps
`default_nettype none

module scoreboard_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire scoreboard_pkg::led_code_t   led_code1,
    input  wire scoreboard_pkg::led_code_t   led_code2,
    input  wire scoreboard_pkg::digit_t      digit1,
    input  wire scoreboard_pkg::digit_t      digit2,
    input  wire scoreboard_pkg::screen_e     lcd_screen,
    output scoreboard_pkg::rgb_t             rgb1,
    output scoreboard_pkg::rgb_t             rgb2,
    output scoreboard_pkg::seg_t             seg_data,
    output scoreboard_pkg::scan_pos_t        seg_pos,
    output wire                              lcd_e,
    output scoreboard_pkg::lcd_bus_t         lcd
);

    scoreboard_pkg::lcd_state_e state;
    scoreboard_pkg::interval_t  interval;

    assign lcd_e = clk;  // Enable strobes every cycle

    rgb_indicator u_rgb (
        .clk       (clk),
        .rst       (rst),
        .led_code1 (led_code1),
        .led_code2 (led_code2),
        .rgb1      (rgb1),
        .rgb2      (rgb2)
    );

    digit_scanner u_scan (
        .clk      (clk),
        .rst      (rst),
        .digit1   (digit1),
        .digit2   (digit2),
        .seg_data (seg_data),
        .seg_pos  (seg_pos)
    );

    lcd_sequencer u_lcd_seq (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .interval (interval)
    );

    lcd_message_rom u_lcd_rom (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .interval   (interval),
        .lcd_screen (lcd_screen),
        .lcd        (lcd)
    );

endmodule

`default_nettype wire

//--- tb/scoreboard_model.svh
`ifndef SCOREBOARD_MODEL_SVH
`define SCOREBOARD_MODEL_SVH

localparam int POWERUP_CYCLES = `POWER_WAIT_LEN + `FUNC_SET_LEN + `ENTRY_MODE_LEN
                                + `DISP_ON_LEN + 4;
localparam int FRAME_CYCLES   = 2 * `LINE_LEN + `HOME_LEN + `CLEAR_LEN + 4;

// One-hot lines, red in the top bit
function automatic scoreboard_pkg::rgb_t rgb_for_code(input scoreboard_pkg::led_code_t code);
    if (code == 2'd0) begin
        rgb_for_code = 3'b000;
    end else begin
        rgb_for_code = 3'b100 >> (code - 2'd1);
    end
endfunction

function automatic scoreboard_pkg::seg_t segments_for_digit(input scoreboard_pkg::digit_t d);
    case (d)
        3'd1:    segments_for_digit = 7'b0110000;
        3'd2:    segments_for_digit = 7'b1101101;
        3'd3:    segments_for_digit = 7'b1111001;
        3'd4:    segments_for_digit = 7'b0110011;
        3'd5:    segments_for_digit = 7'b1011011;
        default: segments_for_digit = 7'b0000000;
    endcase
endfunction

// Nine characters of text, * marks a heart
function automatic string screen_line(input scoreboard_pkg::screen_e scr, input bit second);
    screen_line = "         ";
    if (scr == scoreboard_pkg::SCREEN_P1_WIN || scr == scoreboard_pkg::SCREEN_P2_WIN) begin
        if (second) begin
            screen_line = " *** *** ";
        end else if (scr == scoreboard_pkg::SCREEN_P1_WIN) begin
            screen_line = " P1 Win  ";
        end else begin
            screen_line = " P2 Win  ";
        end
    end
endfunction

// Bus word for step t counted from the first active edge
function automatic scoreboard_pkg::lcd_bus_t lcd_word_at(input int t,
                                                         input scoreboard_pkg::screen_e scr);
    int                       cmd_start;
    int                       f;
    int                       pos;
    string                    text;
    scoreboard_pkg::lcd_bus_t w;
    cmd_start = `POWER_WAIT_LEN + 1;
    w = {1'b0, 1'b0, 8'h00};
    if (t < cmd_start) begin
        w = {1'b1, 1'b1, 8'h00};
    end else if (t < cmd_start + `FUNC_SET_LEN + 1) begin
        w.data = `CMD_FUNC_SET;
    end else if (t < cmd_start + `FUNC_SET_LEN + `ENTRY_MODE_LEN + 2) begin
        w.data = `CMD_ENTRY_MODE;
    end else if (t < POWERUP_CYCLES) begin
        w.data = `CMD_DISP_ON;
    end else begin
        f = (t - POWERUP_CYCLES) % FRAME_CYCLES;
        if (f >= FRAME_CYCLES - `CLEAR_LEN - 1) begin
            w.data = `CMD_CLEAR;
        end else if (f >= 2 * (`LINE_LEN + 1)) begin
            w.data = `CMD_HOME;
        end else begin
            pos = f % (`LINE_LEN + 1);
            if (pos == 0) begin
                w.data = (f == 0) ? `CMD_LINE1_ADDR : `CMD_LINE2_ADDR;
            end else begin
                w.rs = 1'b1;
                text = screen_line(scr, f > `LINE_LEN);
                w.data = (pos > `MSG_LEN) ? `CHAR_SPACE : text[pos-1];
                if (w.data == "*") begin
                    w.data = `CHAR_HEART;
                end
            end
        end
    end
    lcd_word_at = w;
endfunction

`endif

//--- tb/tb_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

`include "scoreboard_defs.svh"

module tb_scoreboard;

    localparam int G_RESET = 0;
    localparam int G_RGB   = 1;
    localparam int G_SEG   = 2;
    localparam int G_PWR   = 3;
    localparam int G_FRAME = 4;

    `include "scoreboard_model.svh"

    // Power-up, three checked frames plus up to one frame of alignment, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int HOME_POS = 2 * (`LINE_LEN + 1) + 10;  // Frame position inside RETURN_HOME

    logic                      clk;
    logic                      rst;
    scoreboard_pkg::led_code_t led_code1;
    scoreboard_pkg::led_code_t led_code2;
    scoreboard_pkg::digit_t    digit1;
    scoreboard_pkg::digit_t    digit2;
    scoreboard_pkg::screen_e   lcd_screen;
    scoreboard_pkg::rgb_t      rgb1;
    scoreboard_pkg::rgb_t      rgb2;
    scoreboard_pkg::seg_t      seg_data;
    scoreboard_pkg::scan_pos_t seg_pos;
    wire                       lcd_e;
    scoreboard_pkg::lcd_bus_t  lcd;

    scoreboard_pkg::rgb_t      exp_rgb1;
    scoreboard_pkg::rgb_t      exp_rgb2;
    scoreboard_pkg::seg_t      exp_seg;
    scoreboard_pkg::scan_pos_t exp_pos;
    scoreboard_pkg::lcd_bus_t  exp_lcd;
    logic                      exp_in_reset;
    logic                      checking = 1'b0;
    int                        step = 0;  // Active edges since reset release
    int                        exp_step;
    int                        scan_k;
    int                        cycle_count = 0;
    int                        err_count [5];
    int                        mismatches = 0;
    int                        checks = 0;
    int                        tests_passed = 0;
    int                        tests_failed = 0;
    int                        g_rgb;
    int                        g_seg;
    int                        g_lcd;

    scoreboard_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .led_code1  (led_code1),
        .led_code2  (led_code2),
        .digit1     (digit1),
        .digit2     (digit2),
        .lcd_screen (lcd_screen),
        .rgb1       (rgb1),
        .rgb2       (rgb2),
        .seg_data   (seg_data),
        .seg_pos    (seg_pos),
        .lcd_e      (lcd_e),
        .lcd        (lcd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // Expected outputs from the inputs seen at this edge
    always @(posedge clk) begin
        if (!rst) begin
            exp_rgb1 = '0;
            exp_rgb2 = '0;
            exp_seg  = '0;
            exp_pos  = '0;
            exp_lcd  = {1'b1, 1'b1, 8'h00};
            exp_in_reset = 1'b1;
            step = 0;
        end else begin
            exp_rgb1 = rgb_for_code(led_code1);
            exp_rgb2 = rgb_for_code(led_code2);
            scan_k = step % `SCAN_W;
            for (int b = 0; b < `SCAN_W; b++) begin
                exp_pos[b] = (b != scan_k);
            end
            if (scan_k == 0) begin
                exp_seg = segments_for_digit(digit1);
            end else if (scan_k == `SCAN_W - 1) begin
                exp_seg = segments_for_digit(digit2);
            end else begin
                exp_seg = '0;
            end
            exp_lcd = lcd_word_at(step, lcd_screen);
            exp_in_reset = 1'b0;
            exp_step = step;
            step = step + 1;
        end
        checking = 1'b1;
    end

    task automatic record_mismatch(input int group, input string what,
                                   input logic [15:0] got, input logic [15:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        err_count[group] = err_count[group] + 1;
        mismatches = mismatches + 1;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            g_rgb = exp_in_reset ? G_RESET : G_RGB;
            g_seg = exp_in_reset ? G_RESET : G_SEG;
            g_lcd = exp_in_reset ? G_RESET : ((exp_step < POWERUP_CYCLES) ? G_PWR : G_FRAME);
            checks = checks + 5;
            if (rgb1 !== exp_rgb1) record_mismatch(g_rgb, "rgb1", rgb1, exp_rgb1);
            if (rgb2 !== exp_rgb2) record_mismatch(g_rgb, "rgb2", rgb2, exp_rgb2);
            if (seg_pos !== exp_pos) record_mismatch(g_seg, "seg_pos", seg_pos, exp_pos);
            if (seg_data !== exp_seg) record_mismatch(g_seg, "seg_data", seg_data, exp_seg);
            if (lcd !== exp_lcd) record_mismatch(g_lcd, "lcd bus", lcd, exp_lcd);
        end
    end

    // lcd_e sampled in the middle of each clock phase
    always @(posedge clk) begin
        #1;
        if (checking) begin
            checks = checks + 1;
            if (lcd_e !== 1'b1) record_mismatch(g_lcd, "lcd_e", lcd_e, 1'b1);
        end
        #2;
        if (checking) begin
            checks = checks + 1;
            if (lcd_e !== 1'b0) record_mismatch(g_lcd, "lcd_e", lcd_e, 1'b0);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int group);
        if (err_count[group] == 0) begin
            $display("%s: passed", name);
            tests_passed = tests_passed + 1;
        end else begin
            $display("%s: failed with %0d mismatches", name, err_count[group]);
            tests_failed = tests_failed + 1;
        end
    endtask

    initial begin
        rst        = 1'b0;
        led_code1  = 2'd1;  // Nonzero during reset
        led_code2  = 2'd3;
        digit1     = 3'd5;
        digit2     = 3'd2;
        lcd_screen = scoreboard_pkg::SCREEN_BLANK;
        for (int i = 0; i < 5; i++) begin
            err_count[i] = 0;
        end
        void'($urandom(61));
        repeat (4) next_cycle();
        rst = 1'b1;
        next_cycle();
        report_test("Test 1 reset values", G_RESET);

        for (int n = 0; n < 40; n++) begin
            led_code1 = $urandom_range(3, 0);
            led_code2 = $urandom_range(3, 0);
            next_cycle();
        end
        next_cycle();
        report_test("Test 2 RGB colours", G_RGB);

        for (int n = 0; n < 10; n++) begin
            digit1 = $urandom_range(7, 0);
            digit2 = $urandom_range(7, 0);
            repeat (16) next_cycle();
        end
        next_cycle();
        report_test("Test 3 seven-segment scan", G_SEG);

        while (step <= POWERUP_CYCLES) begin
            next_cycle();
        end
        next_cycle();
        report_test("Test 4 LCD power-up", G_PWR);

        while ((step - POWERUP_CYCLES) % FRAME_CYCLES != HOME_POS) begin
            next_cycle();
        end
        lcd_screen = scoreboard_pkg::SCREEN_P1_WIN;
        repeat (FRAME_CYCLES) next_cycle();
        lcd_screen = scoreboard_pkg::SCREEN_P2_WIN;
        repeat (FRAME_CYCLES) next_cycle();
        lcd_screen = scoreboard_pkg::SCREEN_BLANK;
        repeat (FRAME_CYCLES) next_cycle();
        next_cycle();
        report_test("Test 5 LCD screens", G_FRAME);

        $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d, checks made: %0d",
                 tests_passed, tests_failed, mismatches, checks);
        if (tests_failed == 0 && mismatches == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
+incdir+tb
rtl/scoreboard_pkg.sv
rtl/rgb_indicator.sv
rtl/digit_scanner.sv
rtl/lcd_sequencer.sv
rtl/lcd_message_rom.sv
rtl/scoreboard_top.sv
tb/tb_scoreboard.sv
